//--- ks10Pkg.sv
// Shared types and constants for the KS10 bus-cycle and run-control slice
// Word bits are numbered 0 (MSB) to 35, as on the KS10 backplane
// Physical addresses are 22 bits, bits 14 to 35 of the bus address word
// Only the NXM timeout and the PI level count may be retuned here

package ks10Pkg;

   ////////////////////////////////////////////////////////////
   // Data and address types
   ////////////////////////////////////////////////////////////

   typedef logic [0:35] word36T;        // One 36-bit data word

   // Bus address with cycle flags
   typedef struct packed {
      logic          rd;                // Read cycle
      logic          wr;                // Write cycle
      logic          io;                // I/O space, not memory
      logic [14:35]  addr;              // Physical address
   } busAddrT;

   ////////////////////////////////////////////////////////////
   // Console
   ////////////////////////////////////////////////////////////

   // All zero is a halt request
   typedef struct packed {
      logic run;                        // Run, clears NXM
      logic cont;                       // Continue, keeps NXM
      logic exec;                       // Execute one bus cycle
   } cslCmdT;

   // Run-control states
   typedef enum logic [1:0] {
      HALT = 2'd0,                      // Stopped
      IDLE = 2'd1,                      // Running, no bus cycle
      WAIT = 2'd2                       // Bus cycle in progress
   } ctlStateT;

   ////////////////////////////////////////////////////////////
   // Priority interrupts
   ////////////////////////////////////////////////////////////

   typedef logic [0:2] piLevelT;        // 1 highest ... 7 lowest, 0 none

   localparam int PI_LEVELS    = 7;     // Levels 1 to 7
   localparam int NXM_PI_LEVEL = 3;     // NXM requests here

   ////////////////////////////////////////////////////////////
   // Bus timing
   ////////////////////////////////////////////////////////////

   // Wait cycles before a cycle is declared non-existent
   localparam int NXM_TIMEOUT = 15;
   localparam int NXM_CNT_W   = 4;      // Wide enough for NXM_TIMEOUT

endpackage

//--- busReg.sv
// Holding register for one bus payload
// payloadT sets the width; any packed type works
// Captures d on load, holds otherwise, clears to zero on reset

`timescale 1ns/1ps

module busReg #(
   parameter type payloadT = logic       // Payload type
) (
   input  logic    clk,                  // Clock
   input  logic    arstN,                // Async reset, active low
   input  logic    load,                 // Capture enable
   input  payloadT d,                    // Incoming payload
   output payloadT q                     // Held payload
);

   payloadT held;

   ////////////////////////////////////////////////////////////
   // Register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         held <= '0;
      end else if (load) begin
         held <= d;
      end
   end

   // Stable for the whole bus cycle
   assign q = held;

endmodule

//--- nxmTimer.sv
// Non-existent memory watchdog
// Counts WAIT cycles; pulses in the NXM_TIMEOUT-th one without an ack
// Pulse is suppressed by a coincident cpuAck
// Counter clears whenever the bus is idle

`timescale 1ns/1ps

module nxmTimer (
   input  logic clk,                     // Clock
   input  logic arstN,                   // Async reset, active low
   input  logic busWait,                 // Cycle in progress
   input  logic cpuAck,                  // Bus acknowledge
   output logic nxmTimeout               // One-cycle timeout pulse
);

   logic [ks10Pkg::NXM_CNT_W-1:0] waitCnt;   // Earlier wait cycles
   logic                          counting;

   assign counting = busWait & ~cpuAck;

   ////////////////////////////////////////////////////////////
   // Wait counter
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         waitCnt <= '0;
      end else if (counting) begin
         waitCnt <= waitCnt + 1'b1;
      end else begin
         waitCnt <= '0;                  // Idle or acked
      end
   end

   // Count holds N-1 during the Nth wait cycle
   assign nxmTimeout = counting &
      (waitCnt == ks10Pkg::NXM_CNT_W'(ks10Pkg::NXM_TIMEOUT - 1));

endmodule

//--- consoleCtl.sv
// Run-control and bus-cycle FSM
// Console strobes are honoured in HALT or IDLE only, dropped in WAIT
// A console strobe wins over an opReq in the same cycle
// One bus cycle per accepted opReq, ended by cpuAck or the NXM timer

`timescale 1ns/1ps

module consoleCtl (
   input  logic             clk,         // Clock
   input  logic             arstN,       // Async reset, active low
   input  logic             cslSet,      // Console command strobe
   input  ks10Pkg::cslCmdT  cslCmd,      // Command qualifier
   input  logic             opReq,       // Start a bus cycle
   input  logic             cpuAck,      // Bus acknowledge
   input  logic             nxmTimeout,  // Timer expired
   output logic             addrLoad,    // Capture address and data
   output logic             ackTake,     // Capture read data
   output logic             busWait,     // Cycle in progress
   output logic             cpuReq,      // Bus request level
   output logic             rdValid,     // Read data valid pulse
   output logic             cpuRun,      // Running, run mode
   output logic             cpuExec,     // Running, exec mode
   output logic             cpuCont,     // Continue pulse
   output logic             cpuHalt,     // Halted
   output logic             nxmFlag      // Sticky non-existent memory
);

   ks10Pkg::ctlStateT state;
   logic execMode;                       // Single bus cycle, then halt
   logic cmdTake;

   // Strobe qualification
   assign cmdTake  = cslSet & (state != ks10Pkg::WAIT);
   assign addrLoad = opReq & (state == ks10Pkg::IDLE) & ~cmdTake;

   assign busWait  = (state == ks10Pkg::WAIT);
   assign ackTake  = busWait & cpuAck;   // Ack only counts in WAIT
   assign cpuReq   = busWait;

   // Status from state
   assign cpuHalt  = (state == ks10Pkg::HALT);
   assign cpuRun   = ~cpuHalt & ~execMode;
   assign cpuExec  = ~cpuHalt & execMode;

   ////////////////////////////////////////////////////////////
   // State, mode and flags
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state    <= ks10Pkg::HALT;
         execMode <= 1'b0;
         nxmFlag  <= 1'b0;
         cpuCont  <= 1'b0;
         rdValid  <= 1'b0;
      end else begin
         cpuCont <= 1'b0;                // Single-cycle pulse
         rdValid <= ackTake;
         if (cmdTake) begin
            // Priority run, cont, exec, then halt
            if (cslCmd.run) begin
               state    <= ks10Pkg::IDLE;
               execMode <= 1'b0;
               nxmFlag  <= 1'b0;
            end else if (cslCmd.cont) begin
               state    <= ks10Pkg::IDLE;
               execMode <= 1'b0;
               cpuCont  <= 1'b1;
            end else if (cslCmd.exec) begin
               state    <= ks10Pkg::IDLE;
               execMode <= 1'b1;
            end else begin
               state    <= ks10Pkg::HALT;
               execMode <= 1'b0;
            end
         end else if (addrLoad) begin
            state <= ks10Pkg::WAIT;
         end else if (ackTake) begin
            // Ack beats a coincident timeout
            state    <= execMode ? ks10Pkg::HALT : ks10Pkg::IDLE;
            execMode <= 1'b0;
         end else if (nxmTimeout) begin
            state    <= ks10Pkg::HALT;   // Nobody answered
            execMode <= 1'b0;
            nxmFlag  <= 1'b1;
         end
      end
   end

endmodule

//--- piCtl.sv
// Priority interrupt encoder
// Level 1 is the highest priority, level 7 the lowest
// NXM flag requests on NXM_PI_LEVEL alongside the Unibus
// Outputs lag the request inputs by one clock

`timescale 1ns/1ps

module piCtl (
   input  logic                       clk,       // Clock
   input  logic                       arstN,     // Async reset, active low
   input  logic [1:ks10Pkg::PI_LEVELS] ubaIntr,  // Unibus requests
   input  logic                       nxmFlag,   // Sticky NXM flag
   output ks10Pkg::piLevelT           piReqPri,  // Requested level
   output logic                       piIntr     // Any level active
);

   logic [1:ks10Pkg::PI_LEVELS] piReq;   // Merged requests
   ks10Pkg::piLevelT            encPri;

   // Fold NXM into its level
   always_comb begin
      piReq                        = ubaIntr;
      piReq[ks10Pkg::NXM_PI_LEVEL] = ubaIntr[ks10Pkg::NXM_PI_LEVEL] | nxmFlag;
   end

   ////////////////////////////////////////////////////////////
   // Encoder
   ////////////////////////////////////////////////////////////

   // Scan low to high priority, last hit wins
   always_comb begin
      encPri = '0;
      for (int lvl = ks10Pkg::PI_LEVELS; lvl >= 1; lvl--) begin
         if (piReq[lvl]) begin
            encPri = ks10Pkg::piLevelT'(lvl);
         end
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         piReqPri <= '0;                 // None
         piIntr   <= 1'b0;
      end else begin
         piReqPri <= encPri;
         piIntr   <= |piReq;
      end
   end

endmodule

//--- cpuCtl.sv
// Top of the KS10 bus-cycle and run-control slice
// The microcode is replaced by opReq strobes from outside
// cpuAddr and cpuDataO hold from the accepted opReq until the next one
// rdData holds the word taken with the last acknowledge

`timescale 1ns/1ps

module cpuCtl (
   input  logic                       clk,       // Clock
   input  logic                       arstN,     // Async reset, active low
   // Console
   input  logic                       cslSet,    // Command strobe
   input  ks10Pkg::cslCmdT            cslCmd,    // Run, cont, exec
   // Operation request
   input  logic                       opReq,     // Start a bus cycle
   input  ks10Pkg::busAddrT           opAddr,    // Address and flags
   input  ks10Pkg::word36T            opData,    // Write word
   // Bus
   input  logic                       cpuAck,    // Bus acknowledge
   input  ks10Pkg::word36T            cpuDataI,  // Bus data in
   input  logic [1:ks10Pkg::PI_LEVELS] ubaIntr,  // Unibus interrupts
   output logic                       cpuReq,    // Bus request
   output ks10Pkg::busAddrT           cpuAddr,   // Bus address
   output ks10Pkg::word36T            cpuDataO,  // Bus data out
   output ks10Pkg::word36T            rdData,    // Read word
   output logic                       rdValid,   // Read word valid
   // Status
   output logic                       cpuRun,
   output logic                       cpuExec,
   output logic                       cpuCont,
   output logic                       cpuHalt,
   output logic                       nxmFlag,   // Non-existent memory
   output logic                       piIntr,    // Interrupt pending
   output ks10Pkg::piLevelT           piReqPri   // Pending level
);

   logic addrLoad;                       // Capture opAddr/opData
   logic ackTake;                        // Capture cpuDataI
   logic busWait;
   logic nxmTimeout;

   ////////////////////////////////////////////////////////////
   // Control
   ////////////////////////////////////////////////////////////

   consoleCtl uConsoleCtl (
      .clk(clk), .arstN(arstN),
      .cslSet(cslSet), .cslCmd(cslCmd), .opReq(opReq),
      .cpuAck(cpuAck), .nxmTimeout(nxmTimeout),
      .addrLoad(addrLoad), .ackTake(ackTake), .busWait(busWait),
      .cpuReq(cpuReq), .rdValid(rdValid), .cpuRun(cpuRun),
      .cpuExec(cpuExec), .cpuCont(cpuCont), .cpuHalt(cpuHalt),
      .nxmFlag(nxmFlag)
   );

   nxmTimer uNxmTimer (
      .clk(clk), .arstN(arstN),
      .busWait(busWait), .cpuAck(cpuAck), .nxmTimeout(nxmTimeout)
   );

   ////////////////////////////////////////////////////////////
   // Bus payload registers
   ////////////////////////////////////////////////////////////

   busReg #(.payloadT(ks10Pkg::busAddrT)) uAddrReg (
      .clk(clk), .arstN(arstN), .load(addrLoad), .d(opAddr), .q(cpuAddr)
   );

   busReg #(.payloadT(ks10Pkg::word36T)) uWrReg (
      .clk(clk), .arstN(arstN), .load(addrLoad), .d(opData), .q(cpuDataO)
   );

   busReg #(.payloadT(ks10Pkg::word36T)) uRdReg (
      .clk(clk), .arstN(arstN), .load(ackTake), .d(cpuDataI), .q(rdData)
   );

   // Interrupts, NXM included
   piCtl uPiCtl (
      .clk(clk), .arstN(arstN), .ubaIntr(ubaIntr), .nxmFlag(nxmFlag),
      .piReqPri(piReqPri), .piIntr(piIntr)
   );

endmodule

//--- cpuCtl_chk.sv
// Concurrent checks on the cpuCtl ports, bound into cpuCtl as uChk
// Run state is rebuilt from cpuReq and cpuHalt, not read from the FSM
// Each failure raises $error and bumps failCnt

`timescale 1ns/1ps

module cpuCtl_chk (
   input logic                        clk, arstN,
   input logic                        cslSet, opReq, cpuAck,
   input ks10Pkg::cslCmdT             cslCmd,
   input ks10Pkg::busAddrT            opAddr, cpuAddr,
   input ks10Pkg::word36T             opData, cpuDataO, cpuDataI, rdData,
   input logic [1:ks10Pkg::PI_LEVELS] ubaIntr,
   input logic                        cpuReq, rdValid, cpuRun, cpuExec,
   input logic                        cpuCont, cpuHalt, nxmFlag, piIntr,
   input ks10Pkg::piLevelT            piReqPri
);

   ks10Pkg::ctlStateT obsState;          // State seen at the ports
   logic              cmdOk;             // Console strobe taken
   logic              opOk;              // opReq taken
   int                reqLen;            // Unacked WAIT cycles so far
   int                failCnt = 0;

   assign obsState = cpuReq ? ks10Pkg::WAIT : (cpuHalt ? ks10Pkg::HALT : ks10Pkg::IDLE);
   assign cmdOk    = cslSet && (obsState != ks10Pkg::WAIT);
   assign opOk     = opReq && !cslSet && (obsState == ks10Pkg::IDLE);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         reqLen <= 0;
      end else if (cpuReq && !cpuAck) begin
         reqLen <= reqLen + 1;
      end else begin
         reqLen <= 0;
      end
   end

   // Lowest set level wins, 0 if none
   function automatic ks10Pkg::piLevelT topLevel(input logic [1:ks10Pkg::PI_LEVELS] req,
                                                 input logic nxm);
      logic [1:ks10Pkg::PI_LEVELS] merged;
      merged = req;
      merged[ks10Pkg::NXM_PI_LEVEL] = merged[ks10Pkg::NXM_PI_LEVEL] | nxm;
      for (int lvl = 1; lvl <= ks10Pkg::PI_LEVELS; lvl++) begin
         if (merged[lvl]) return ks10Pkg::piLevelT'(lvl);
      end
      return '0;
   endfunction

   task automatic flagFail(input string what);
      failCnt++;
      $error("%s", what);
   endtask

   ////////////////////////////////////////////////////////////
   // Console and run state
   ////////////////////////////////////////////////////////////

   aReset: assert property (@(posedge clk) $rose(arstN) |-> cpuHalt && !cpuReq && !cpuRun
      && !cpuExec && !cpuCont && !rdValid && !nxmFlag && !piIntr && piReqPri == '0)
      else flagFail("outputs not at reset values after reset");
   aRun: assert property (@(posedge clk) disable iff (!arstN)
      cmdOk && cslCmd.run |=> cpuRun && !cpuHalt && !nxmFlag)
      else flagFail("run command did not start run mode with NXM cleared");
   aCont: assert property (@(posedge clk) disable iff (!arstN)
      cmdOk && !cslCmd.run && cslCmd.cont |=> cpuRun && cpuCont && nxmFlag == $past(nxmFlag))
      else flagFail("cont command gave wrong run state, pulse or NXM flag");
   aContPulse: assert property (@(posedge clk) disable iff (!arstN)
      cpuCont |-> $past(cmdOk && !cslCmd.run && cslCmd.cont))
      else flagFail("cpuCont high without a cont command the cycle before");
   aExec: assert property (@(posedge clk) disable iff (!arstN)
      cmdOk && !cslCmd.run && !cslCmd.cont && cslCmd.exec |=> cpuExec && !cpuRun)
      else flagFail("exec command did not enter exec mode");
   aHalt: assert property (@(posedge clk) disable iff (!arstN)
      cmdOk && cslCmd == '0 |=> cpuHalt && !cpuRun && !cpuExec)
      else flagFail("halt command did not halt");

   ////////////////////////////////////////////////////////////
   // Bus cycles
   ////////////////////////////////////////////////////////////

   aStart: assert property (@(posedge clk) disable iff (!arstN)
      opOk |=> cpuReq && cpuAddr == $past(opAddr) && cpuDataO == $past(opData))
      else flagFail("accepted opReq did not start a cycle with its address and data");
   aNoStart: assert property (@(posedge clk) disable iff (!arstN)
      $rose(cpuReq) |-> $past(opOk))
      else flagFail("cpuReq rose without an opReq taken in IDLE");
   aHold: assert property (@(posedge clk) disable iff (!arstN)
      cpuReq && $past(cpuReq) |-> $stable(cpuAddr) && $stable(cpuDataO))
      else flagFail("cpuAddr or cpuDataO changed during a bus cycle");
   aRead: assert property (@(posedge clk) disable iff (!arstN)
      cpuReq && cpuAck |=> rdValid && !cpuReq && rdData == $past(cpuDataI)
      && nxmFlag == $past(nxmFlag) && cpuRun == $past(cpuRun))
      else flagFail("acknowledged cycle did not complete with the read word");
   aRdPulse: assert property (@(posedge clk) disable iff (!arstN)
      rdValid |-> $past(cpuReq && cpuAck))
      else flagFail("rdValid high without an acknowledge the cycle before");
   aWaitLen: assert property (@(posedge clk) disable iff (!arstN)
      cpuReq && !cpuAck && reqLen < ks10Pkg::NXM_TIMEOUT - 1 |=> cpuReq)
      else flagFail("bus cycle ended early without an acknowledge");
   aNxm: assert property (@(posedge clk) disable iff (!arstN)
      cpuReq && !cpuAck && reqLen == ks10Pkg::NXM_TIMEOUT - 1 |=> cpuHalt && nxmFlag && !cpuReq)
      else flagFail("unacknowledged cycle did not end in HALT with NXM set");
   aExecEnd: assert property (@(posedge clk) disable iff (!arstN)
      $fell(cpuReq) && $past(cpuExec) |-> cpuHalt)
      else flagFail("exec mode did not return to HALT after its bus cycle");

   // Interrupt encoder, one cycle behind its inputs
   aPri: assert property (@(posedge clk) disable iff (!arstN)
      piReqPri == topLevel($past(ubaIntr), $past(nxmFlag))
      && piIntr == $past(|ubaIntr | nxmFlag))
      else flagFail("priority level or interrupt flag does not match the requests");

endmodule

bind cpuCtl cpuCtl_chk uChk (.*);

//--- tbCpuCtl.sv
// Testbench for cpuCtl
// Stimulus comes from a 16-bit Fibonacci LFSR, seed 15, one step per bit
// Timing and state rules are checked by cpuCtl_chk, bound as uChk
// Read words are also scored here against the words sent with each ack

`timescale 1ns/1ps

module tbCpuCtl;

   logic                        clk;
   logic                        arstN;
   logic                        cslSet;
   ks10Pkg::cslCmdT             cslCmd;
   logic                        opReq;
   ks10Pkg::busAddrT            opAddr;
   ks10Pkg::word36T             opData;
   logic                        cpuAck;
   ks10Pkg::word36T             cpuDataI;
   logic [1:ks10Pkg::PI_LEVELS] ubaIntr;
   logic                        cpuReq, rdValid, cpuRun, cpuExec;
   logic                        cpuCont, cpuHalt, nxmFlag, piIntr;
   ks10Pkg::busAddrT            cpuAddr;
   ks10Pkg::word36T             cpuDataO, rdData;
   ks10Pkg::piLevelT            piReqPri;

   logic [15:0]       lfsr = 16'd15;     // Seed
   ks10Pkg::word36T   expQ[$];           // Words sent with acks
   ks10Pkg::word36T   expWord;
   int                sbErr = 0;
   int                cycleCnt = 0;

   cpuCtl uut (.*);

   // Taps for x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // n fresh bits, right-aligned
   task automatic randBits(input int n, output logic [35:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsrNext(lfsr);
         v    = {v[34:0], lfsr[15]};
      end
   endtask

   // One strobe, then settle
   task automatic console(input logic [2:0] cmd);
      cslCmd <= cmd;                     // {run, cont, exec}
      cslSet <= 1'b1;
      @(posedge clk);
      cslSet <= 1'b0;
      @(posedge clk);
   endtask

   // Second opReq lands in WAIT and must be dropped
   task automatic busCycle(input bit giveAck);
      logic [35:0] v;
      logic [35:0] dly;
      randBits(25, v);
      opAddr <= v[24:0];
      randBits(36, v);
      opData <= v;
      opReq  <= 1'b1;
      @(posedge clk);
      randBits(25, v);
      opAddr <= v[24:0];                 // Must not reach cpuAddr
      @(posedge clk);
      opReq <= 1'b0;
      if (giveAck) begin
         randBits(3, dly);
         repeat (dly % 7) @(posedge clk);   // 0 to 6 wait cycles
         randBits(36, v);
         cpuAck   <= 1'b1;
         cpuDataI <= v;
         expQ.push_back(v);
         @(posedge clk);
         cpuAck <= 1'b0;
      end
      while (cpuReq) @(posedge clk);     // Ack or NXM ends it
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Run needs a few hundred cycles
   always @(posedge clk) begin
      cycleCnt <= cycleCnt + 1;
      if (cycleCnt == 2000) begin
         $display("Timeout, run did not finish within %0d cycles", cycleCnt);
         $display("Test failures found");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read scoreboard
   ////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (arstN && rdValid) begin
         if (expQ.size() == 0) begin
            $display("rdValid pulsed with no acknowledge pending");
            sbErr++;
         end else begin
            expWord = expQ.pop_front();
            if (rdData !== expWord) begin
               $display("Error: rdData is %h, expected %h", rdData, expWord);
               sbErr++;
            end
         end
      end
   end

   initial begin
      logic [35:0] v;
      arstN    = 1'b0;
      cslSet   = 1'b0;
      cslCmd   = '0;
      opReq    = 1'b0;
      opAddr   = '0;
      opData   = '0;
      cpuAck   = 1'b0;
      cpuDataI = '0;
      ubaIntr  = '0;
      repeat (2) @(posedge clk);
      arstN <= 1'b1;
      @(posedge clk);
      busCycle(1'b0);                    // Halted, opReq ignored
      console(3'b111);                   // Run wins
      for (int i = 0; i < 40; i++) begin
         randBits(7, v);
         ubaIntr <= v[6:0];
         busCycle(1'b1);
      end
      console(3'b000);                   // Halt while running
      console(3'b011);                   // Cont beats exec
      console(3'b001);
      busCycle(1'b1);                    // Exec, one cycle then HALT
      busCycle(1'b0);                    // Dropped while halted
      ubaIntr <= '0;
      console(3'b100);
      busCycle(1'b0);                    // No ack, NXM
      console(3'b010);                   // NXM stays set
      console(3'b001);
      busCycle(1'b0);                    // Exec cycle ends by NXM
      console(3'b110);                   // Run clears NXM
      ubaIntr <= 7'b0000001;             // Level 7 only
      repeat (3) @(posedge clk);
      if (expQ.size() != 0) begin
         $display("%0d acknowledged reads never gave rdValid", expQ.size());
         sbErr += expQ.size();
      end
      $display("Assertion failures: %0d, scoreboard errors: %0d",
               uut.uChk.failCnt, sbErr);
      if (uut.uChk.failCnt == 0 && sbErr == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- files.f
ks10Pkg.sv
busReg.sv
nxmTimer.sv
consoleCtl.sv
piCtl.sv
cpuCtl.sv
cpuCtl_chk.sv
tbCpuCtl.sv

//--- Makefile
TOP = tbCpuCtl
RTL = ks10Pkg.sv busReg.sv nxmTimer.sv consoleCtl.sv piCtl.sv cpuCtl.sv

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

obj_dir/V$(TOP): files.f $(RTL) cpuCtl_chk.sv tbCpuCtl.sv
	verilator --binary --assert -f files.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --top-module cpuCtl $(RTL)

clean:
	rm -rf obj_dir
